// ==== hdl/icachePkg.sv ====
`default_nettype none

package icachePkg;

	localparam int PcWidth = 48;
	localparam int LineAddrWidth = 44;		// PC with the byte-in-line bits dropped
	localparam int LineWidth = 128;
	localparam int WindowWidth = 96;		// Six 16-bit words
	localparam int IndexBits = 6;			// Line-address bits 6..1
	localparam int BankLines = 1 << IndexBits;
	localparam int EpochWidth = 8;
	localparam int SeqRovWidth = 4;
	localparam int SeqSlots = 1 << SeqRovWidth;

	typedef logic [LineAddrWidth-1:0] lineAddrT;
	typedef logic [EpochWidth-1:0] epochT;

	typedef enum logic [1:0]
	{
		pcOkOk = 2'b00,
		pcOkHold = 2'b01
	} pcOkT;

	// Cache-control opcode on the fetch side
	typedef enum logic [4:0]
	{
		fetchOpNone = 5'h00,
		fetchOpFlush = 5'h04
	} fetchOpT;

	// Top two bits give the class, 01 is a response
	typedef enum logic [7:0]
	{
		ringIdle = 8'h00,
		ringLoadReq = 8'h88,
		ringLoadResp = 8'h70,		// Response with OK
		ringOther = 8'hC4
	} ringOpT;

	typedef struct packed
	{
		logic [7:0] node;			// Requesting unit
		logic oddBank;
		logic [2:0] spare;
		logic [SeqRovWidth-1:0] rov;
	} ringSeqT;

	typedef struct packed
	{
		ringSeqT seq;
		ringOpT op;
		logic [PcWidth-1:0] addr;
		logic [LineWidth-1:0] data;
	} ringFlitT;

	typedef struct packed
	{
		logic valid;
		logic [IndexBits-1:0] index;
		lineAddrT tag;
		logic [LineWidth-1:0] data;
	} bankFillT;

	typedef struct packed
	{
		lineAddrT tag;
		epochT epoch;				// Epoch at fill time
		logic [LineWidth-1:0] data;
	} bankLineT;

endpackage

`default_nettype wire

// ==== hdl/icacheBank.sv ====
`default_nettype none
`timescale 1ns/100ps

module icacheBank (
	input logic clock,
	input logic [icachePkg::IndexBits-1:0] readIndex,
	output icachePkg::bankLineT readLine,
	input icachePkg::bankFillT fill,
	input icachePkg::epochT epoch
);

	import icachePkg::*;

	bankLineT lineMem [BankLines];
	bankLineT fillLine;
	logic fillHitsRead;

	// Powers up with epoch zero, which never matches
	initial
	begin
		for (int i = 0; i < BankLines; i++)
		begin
			lineMem[i] = '0;
		end
	end

	assign fillLine = '{tag: fill.tag, epoch: epoch, data: fill.data};
	assign fillHitsRead = fill.valid && (fill.index == readIndex);

	always @(posedge clock)
	begin
		if (fill.valid)
		begin
			lineMem[fill.index] <= fillLine;
		end
	end

	// Registered read, a same-cycle fill is passed through
	always_ff @(posedge clock)
	begin
		if (fillHitsRead)
		begin
			readLine <= fillLine;
		end
		else
		begin
			readLine <= lineMem[readIndex];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/icacheFlushControl.sv ====
`default_nettype none
`timescale 1ns/100ps

module icacheFlushControl (
	input logic clock,
	input logic reset,
	input icachePkg::fetchOpT fetchOp,
	output icachePkg::epochT epoch
);

	import icachePkg::*;

	fetchOpT opA;
	fetchOpT opB;
	logic flushSeen;		// opB was already flush last cycle
	logic flushEdge;
	epochT epochReg = '0;	// Same start value as the bank entries
	epochT epochNext;

	assign flushEdge = (opB == fetchOpFlush) && !flushSeen;
	assign epochNext = (epochReg == '1) ? epochT'(1) : epochReg + 1'b1;	// Skip zero on wrap
	assign epoch = epochReg;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			opA <= fetchOpNone;
			opB <= fetchOpNone;
			flushSeen <= 1'b0;
		end
		else
		begin
			opA <= fetchOp;
			opB <= opA;
			flushSeen <= (opB == fetchOpFlush);
		end
	end

	// Reset counts as a flush too
	always @(posedge clock)
	begin
		if (reset || flushEdge)
		begin
			epochReg <= epochNext;
		end
	end

	// Stays put or moves up by one, all ones wraps to one
	epochStep: assert property (@(posedge clock) disable iff (reset)
		(epochReg != '0) && ((epochReg == $past(epochReg))
		|| (epochReg == $past(epochReg) + 1'b1)
		|| (($past(epochReg) == '1) && (epochReg == epochT'(1)))))
		else $error("epoch moved by more than one step or became zero");

endmodule

`default_nettype wire

// ==== hdl/icacheFetchPipe.sv ====
`default_nettype none
`timescale 1ns/100ps

module icacheFetchPipe (
	input logic clock,
	input logic reset,
	input logic [icachePkg::PcWidth-1:0] pc,
	input logic pcHold,
	input logic bundleMode,
	input icachePkg::epochT epoch,
	output logic [icachePkg::IndexBits-1:0] readIndexEven,
	output logic [icachePkg::IndexBits-1:0] readIndexOdd,
	input icachePkg::bankLineT lineEven,
	input icachePkg::bankLineT lineOdd,
	output logic missEven,
	output logic missOdd,
	output icachePkg::lineAddrT missAddrEven,
	output icachePkg::lineAddrT missAddrOdd,
	input logic loadPending,
	output logic [icachePkg::WindowWidth-1:0] pcVal,
	output logic [2:0] pcStep,
	output icachePkg::pcOkT pcOk
);

	import icachePkg::*;

	logic [PcWidth-1:0] pcSel;
	logic [PcWidth-1:0] pcReg;		// PC being looked up in stage B
	lineAddrT lineAddr;
	lineAddrT lineNext;
	lineAddrT addrEven;
	lineAddrT addrOdd;
	lineAddrT reqEven;
	lineAddrT reqOdd;
	logic validB;
	logic [LineWidth-1:0] curData;
	logic [LineWidth-1:0] nextData;
	logic [2*LineWidth-1:0] linePair;
	logic [WindowWidth-1:0] window;
	logic [15:0] word0;
	logic [15:0] word2;

	function automatic logic opWide(input logic [15:0] word);
		return word[15:13] == 3'b111;
	endfunction

	// Bundle marker sits in bits 12..9 of a 32-bit op
	function automatic logic opMarked(input logic [15:0] word);
		logic [3:0] sel;
		sel = word[12:9];
		return opWide(word) &&
			(sel inside {4'b0101, 4'b0111, 4'b1010, 4'b1011, 4'b1110, 4'b1111});
	endfunction

	// Stage A
	assign pcSel = pcHold ? pcReg : pc;			// Hold re-reads the stored PC
	assign lineAddr = pcSel[PcWidth-1:4];
	assign lineNext = lineAddr + 1'b1;

	always_comb
	begin
		if (lineAddr[0])
		begin
			addrOdd = lineAddr;
			addrEven = lineNext;
		end
		else
		begin
			addrEven = lineAddr;
			addrOdd = lineNext;
		end
	end

	assign readIndexEven = addrEven[IndexBits:1];
	assign readIndexOdd = addrOdd[IndexBits:1];

	always_ff @(posedge clock)
	begin
		pcReg <= pcSel;
		reqEven <= addrEven;
		reqOdd <= addrOdd;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			validB <= 1'b0;
		end
		else
		begin
			validB <= 1'b1;
		end
	end

	// Stage B
	assign missEven = validB && ((lineEven.tag != reqEven) || (lineEven.epoch != epoch));
	assign missOdd = validB && ((lineOdd.tag != reqOdd) || (lineOdd.epoch != epoch));
	assign missAddrEven = reqEven;
	assign missAddrOdd = reqOdd;

	assign curData = pcReg[4] ? lineOdd.data : lineEven.data;
	assign nextData = pcReg[4] ? lineEven.data : lineOdd.data;
	assign linePair = {nextData, curData};
	assign window = linePair[pcReg[3:1] * 16 +: WindowWidth];	// Start at the PC's word
	assign word0 = window[15:0];
	assign word2 = window[47:32];
	assign pcVal = window;

	always_comb
	begin
		if (bundleMode && opMarked(word0))
		begin
			pcStep = opMarked(word2) ? 3'd6 : 3'd4;	// Three- or two-wide bundle
		end
		else if (opWide(word0))
		begin
			pcStep = 3'd2;
		end
		else
		begin
			pcStep = 3'd1;
		end
	end

	assign pcOk = (!validB || missEven || missOdd || loadPending) ? pcOkHold : pcOkOk;

endmodule

`default_nettype wire

// ==== hdl/icacheRingPort.sv ====
`default_nettype none
`timescale 1ns/100ps

module icacheRingPort #(
	parameter logic [7:0] NodeId = 8'h00
) (
	input logic clock,
	input logic reset,
	input logic missEven,
	input logic missOdd,
	input icachePkg::lineAddrT missAddrEven,
	input icachePkg::lineAddrT missAddrOdd,
	output logic loadPending,
	output icachePkg::bankFillT fillEven,
	output icachePkg::bankFillT fillOdd,
	input icachePkg::ringFlitT ringIn,
	output icachePkg::ringFlitT ringOut
);

	import icachePkg::*;

	logic pendingEven;
	logic pendingOdd;
	logic [SeqRovWidth-1:0] rov;
	lineAddrT seqTable [SeqSlots];		// Line address per outstanding tag
	logic respForUs;
	logic respEven;
	logic respOdd;
	logic slotFree;
	logic issueEven;
	logic issueOdd;
	lineAddrT issueAddr;
	lineAddrT respAddr;
	ringFlitT reqFlit;
	logic fillValidEven;
	logic fillValidOdd;
	logic [IndexBits-1:0] fillIndex;	// Shared, one response per cycle
	lineAddrT fillTag;
	logic [LineWidth-1:0] fillData;
	logic ownReqEven;
	logic ownReqOdd;

	assign respForUs = (ringIn.op == ringLoadResp) && (ringIn.seq.node == NodeId);
	assign respEven = respForUs && !ringIn.seq.oddBank;
	assign respOdd = respForUs && ringIn.seq.oddBank;
	assign slotFree = (ringIn.op == ringIdle) || respForUs;	// Consumed response frees the slot

	// Even bank first, nothing new while a fill is still on its way
	assign issueEven = slotFree && missEven && !pendingEven && !fillValidEven;
	assign issueOdd = slotFree && !issueEven && missOdd && !pendingOdd && !fillValidOdd;
	assign issueAddr = issueOdd ? missAddrOdd : missAddrEven;
	assign respAddr = seqTable[ringIn.seq.rov];

	always_comb
	begin
		reqFlit.seq = '{node: NodeId, oddBank: issueOdd, spare: 3'b000, rov: rov};
		reqFlit.op = (issueEven || issueOdd) ? ringLoadReq : ringIdle;
		reqFlit.addr = {issueAddr, 4'h0};
		reqFlit.data = '0;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pendingEven <= 1'b0;
			pendingOdd <= 1'b0;
			rov <= '0;
			ringOut <= '0;
			fillValidEven <= 1'b0;
			fillValidOdd <= 1'b0;
		end
		else
		begin
			pendingEven <= issueEven || (pendingEven && !respEven);
			pendingOdd <= issueOdd || (pendingOdd && !respOdd);
			if (issueEven || issueOdd)
			begin
				rov <= rov + 1'b1;
			end
			ringOut <= slotFree ? reqFlit : ringIn;	// Foreign traffic passes unchanged
			fillValidEven <= respEven;
			fillValidOdd <= respOdd;
		end
	end

	always_ff @(posedge clock)
	begin
		if (issueEven || issueOdd)
		begin
			seqTable[rov] <= issueAddr;
		end
		if (respForUs)
		begin
			fillIndex <= respAddr[IndexBits:1];
			fillTag <= respAddr;
			fillData <= ringIn.data;
		end
	end

	assign fillEven = '{valid: fillValidEven, index: fillIndex, tag: fillTag, data: fillData};
	assign fillOdd = '{valid: fillValidOdd, index: fillIndex, tag: fillTag, data: fillData};
	assign loadPending = pendingEven || pendingOdd;

	// Own requests as they leave on the ring
	assign ownReqEven = (ringOut.op == ringLoadReq) && (ringOut.seq.node == NodeId)
		&& !ringOut.seq.oddBank;
	assign ownReqOdd = (ringOut.op == ringLoadReq) && (ringOut.seq.node == NodeId)
		&& ringOut.seq.oddBank;

	// One load per bank in flight until its response comes back
	oneLoadEven: assert property (@(posedge clock) disable iff (reset)
		ownReqEven |=> !ownReqEven until respEven)
		else $error("second even-bank load before response");

	oneLoadOdd: assert property (@(posedge clock) disable iff (reset)
		ownReqOdd |=> !ownReqOdd until respOdd)
		else $error("second odd-bank load before response");

endmodule

`default_nettype wire

// ==== hdl/icacheTop.sv ====
`default_nettype none
`timescale 1ns/100ps

module icacheTop #(
	parameter logic [7:0] NodeId = 8'h00
) (
	input logic clock,
	input logic reset,
	input logic [icachePkg::PcWidth-1:0] pc,
	input logic pcHold,
	input logic bundleMode,
	input icachePkg::fetchOpT fetchOp,
	output logic [icachePkg::WindowWidth-1:0] pcVal,
	output logic [2:0] pcStep,
	output icachePkg::pcOkT pcOk,
	input icachePkg::ringFlitT ringIn,
	output icachePkg::ringFlitT ringOut
);

	import icachePkg::*;

	epochT epoch;
	logic [IndexBits-1:0] readIndexEven;
	logic [IndexBits-1:0] readIndexOdd;
	bankLineT lineEven;
	bankLineT lineOdd;
	bankFillT fillEven;
	bankFillT fillOdd;
	logic missEven;
	logic missOdd;
	lineAddrT missAddrEven;
	lineAddrT missAddrOdd;
	logic loadPending;

	icacheBank bankEven (.clock, .readIndex(readIndexEven), .readLine(lineEven),
		.fill(fillEven), .epoch);

	icacheBank bankOdd (.clock, .readIndex(readIndexOdd), .readLine(lineOdd),
		.fill(fillOdd), .epoch);

	icacheFlushControl flushControl (.clock, .reset, .fetchOp, .epoch);

	icacheFetchPipe fetchPipe (
		.clock,
		.reset,
		.pc,
		.pcHold,
		.bundleMode,
		.epoch,
		.readIndexEven,
		.readIndexOdd,
		.lineEven,
		.lineOdd,
		.missEven,
		.missOdd,
		.missAddrEven,
		.missAddrOdd,
		.loadPending,
		.pcVal,
		.pcStep,
		.pcOk
	);

	icacheRingPort #(.NodeId(NodeId)) ringPort (
		.clock,
		.reset,
		.missEven,
		.missOdd,
		.missAddrEven,
		.missAddrOdd,
		.loadPending,
		.fillEven,
		.fillOdd,
		.ringIn,
		.ringOut
	);

endmodule

`default_nettype wire

// ==== test/icacheTb.sv ====
`default_nettype none
`timescale 1ns/100ps

module icacheTb;

	import icachePkg::*;

	localparam int ClockPeriod = 100;
	localparam int TestCount = 6;

	logic clock;
	logic reset;
	logic [PcWidth-1:0] pc;
	logic pcHold;
	logic bundleMode;
	fetchOpT fetchOp;
	logic [WindowWidth-1:0] pcVal;
	logic [2:0] pcStep;
	pcOkT pcOk;
	ringFlitT ringIn;
	ringFlitT ringOut;
	integer seed = 68431;
	ringFlitT reqLog [$];			// Every load request seen on ringOut
	ringFlitT reqQueue [$];			// Requests not yet answered
	lineAddrT tableAddr [$];		// Lines with test-written contents
	logic [LineWidth-1:0] tableData [$];

	icacheTop #(.NodeId(8'h2A)) dut0 (.clock, .reset, .pc, .pcHold, .bundleMode, .fetchOp,
		.pcVal, .pcStep, .pcOk, .ringIn, .ringOut);

	initial
	begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	initial
	begin
		#(TestCount * 400 * ClockPeriod);
		failRun("Watchdog expired before all tests finished");
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	// Default word is the low half of its own byte address
	function automatic logic [LineWidth-1:0] lineData(input lineAddrT line);
		logic [LineWidth-1:0] data;
		logic [PcWidth-1:0] base;
		base = {line, 4'h0};
		for (int w = 0; w < 8; w++)
		begin
			data[w*16 +: 16] = base[15:0] + 16'(2 * w);
		end
		for (int i = 0; i < tableAddr.size(); i++)
		begin
			if (tableAddr[i] == line)
			begin
				data = tableData[i];
			end
		end
		return data;
	endfunction

	// Six words from the PC on, may run into the next line
	function automatic logic [WindowWidth-1:0] windowAt(input logic [PcWidth-1:0] addr);
		logic [WindowWidth-1:0] window;
		logic [PcWidth-1:0] wordAddr;
		logic [LineWidth-1:0] data;
		for (int k = 0; k < 6; k++)
		begin
			wordAddr = addr + PcWidth'(2 * k);
			data = lineData(wordAddr[PcWidth-1:4]);
			window[k*16 +: 16] = data[wordAddr[3:1]*16 +: 16];
		end
		return window;
	endfunction

	task automatic checkFetch(input logic [WindowWidth-1:0] gotWindow, input logic [2:0] gotStep,
		input pcOkT gotOk, input logic [WindowWidth-1:0] expWindow, input logic [2:0] expStep,
		input pcOkT expOk, input string what);
		if (gotWindow !== expWindow || gotStep !== expStep || gotOk !== expOk)
		begin
			failRun($sformatf("MISMATCH at %0t: %s gave %h step %0d %s, expected %h step %0d %s",
				$time, what, gotWindow, gotStep, gotOk.name(), expWindow, expStep, expOk.name()));
		end
	endtask

	task automatic checkOk(input pcOkT got, input pcOkT exp, input string what);
		if (got !== exp)
		begin
			failRun($sformatf("MISMATCH at %0t: %s gave pcOk %s, expected %s",
				$time, what, got.name(), exp.name()));
		end
	endtask

	task automatic checkFlit(input ringFlitT got, input ringFlitT exp, input string what);
		if (got !== exp)
		begin
			failRun($sformatf("MISMATCH at %0t: %s gave %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic checkCount(input int got, input int exp, input string what);
		if (got != exp)
		begin
			failRun($sformatf("MISMATCH at %0t: %s gave %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	task automatic watchRing();
		forever
		begin
			@(negedge clock);
			if (ringOut.op == ringLoadReq)
			begin
				reqLog.push_back(ringOut);
				reqQueue.push_back(ringOut);
			end
		end
	endtask

	// Answers requests in order after a random number of idle cycles
	task automatic memoryModel();
		ringFlitT resp;
		int gap;
		forever
		begin
			@(posedge clock);
			if (reqQueue.size() > 0)
			begin
				resp = reqQueue.pop_front();
				gap = {$random(seed)} % 6;
				repeat (gap) @(posedge clock);
				resp.op = ringLoadResp;
				resp.data = lineData(resp.addr[PcWidth-1:4]);
				ringIn <= resp;
				@(posedge clock);
				ringIn <= '0;
			end
		end
	endtask

	task automatic waitReady(input logic [PcWidth-1:0] addr);
		int cycles;
		cycles = 0;
		while (pcOk !== pcOkOk)
		begin
			cycles++;
			if (cycles > 300)
			begin
				failRun($sformatf("Fetch of pc %h never became ready", addr));
			end
			@(posedge clock);
			@(negedge clock);
		end
	endtask

	task automatic fetchPc(input logic [PcWidth-1:0] addr, input logic bundle,
		input logic [2:0] expStep, input logic mayMiss);
		@(posedge clock);
		pc <= addr;
		bundleMode <= bundle;
		@(posedge clock);
		@(negedge clock);
		if (mayMiss)
		begin
			waitReady(addr);
		end
		checkFetch(pcVal, pcStep, pcOk, windowAt(addr), expStep, pcOkOk,
			$sformatf("fetch of pc %h", addr));
	endtask

	// Both lines requested, even bank first, rover counting up
	task automatic checkRequests(input int start, input logic [PcWidth-1:0] addr);
		lineAddrT line;
		ringFlitT expFlit;
		line = addr[PcWidth-1:4];
		checkCount(reqLog.size() - start, 2, "number of load requests");
		expFlit = '0;
		expFlit.seq.node = 8'h2A;
		expFlit.seq.rov = start[3:0];
		expFlit.op = ringLoadReq;
		expFlit.addr = {(line[0] ? line + 1'b1 : line), 4'h0};
		checkFlit(reqLog[start], expFlit, "even-bank request");
		expFlit.seq.oddBank = 1'b1;
		expFlit.seq.rov = start[3:0] + 1'b1;
		expFlit.addr = {(line[0] ? line : line + 1'b1), 4'h0};
		checkFlit(reqLog[start+1], expFlit, "odd-bank request");
	endtask

	task automatic finishMiss(input logic [PcWidth-1:0] addr, input int start);
		waitReady(addr);
		checkFetch(pcVal, pcStep, pcOk, windowAt(addr), 3'd1, pcOkOk, "fetch after fill");
		checkRequests(start, addr);
	endtask

	// First PC goes in on the edge that releases reset
	task automatic coldMissTest();
		int start;
		start = reqLog.size();
		pc <= 48'h1006;
		@(posedge clock);
		@(negedge clock);
		checkOk(pcOk, pcOkHold, "cold fetch");
		finishMiss(48'h1006, start);
	endtask

	task automatic hitsTest();
		int start;
		start = reqLog.size();
		fetchPc(48'h1000, 1'b0, 3'd1, 1'b0);
		fetchPc(48'h1002, 1'b0, 3'd1, 1'b0);
		fetchPc(48'h100C, 1'b0, 3'd1, 1'b0);
		fetchPc(48'h1008, 1'b0, 3'd1, 1'b0);
		fetchPc(48'h100E, 1'b0, 3'd1, 1'b0);
		checkCount(reqLog.size() - start, 0, "load requests during hits");
	endtask

	// 16-bit, unmarked 32-bit, marked, and marked pair across the line end
	task automatic stepTest();
		tableAddr.push_back(44'h204);
		tableData.push_back({16'h0000, 16'hFE00, 16'h0001, 16'h0000,
			16'hEA00, 16'h0000, 16'hEC00, 16'h1234});
		tableAddr.push_back(44'h205);
		tableData.push_back({16'h0007, 16'h0006, 16'h0005, 16'h0004,
			16'h0003, 16'h0002, 16'h0000, 16'hF400});
		for (int b = 1; b >= 0; b--)
		begin
			fetchPc(48'h2040, b[0], 3'd1, 1'b1);
			fetchPc(48'h2042, b[0], 3'd2, 1'b1);
			fetchPc(48'h2046, b[0], (b == 1) ? 3'd4 : 3'd2, 1'b1);
			fetchPc(48'h204A, b[0], 3'd1, 1'b1);
			fetchPc(48'h204C, b[0], (b == 1) ? 3'd6 : 3'd2, 1'b1);
		end
	endtask

	task automatic holdTest();
		logic [PcWidth-1:0] others [3];
		others[0] = 48'h2040;
		others[1] = 48'h2046;
		others[2] = 48'h100C;
		fetchPc(48'h1004, 1'b0, 3'd1, 1'b0);
		for (int i = 0; i < 3; i++)
		begin
			@(posedge clock);
			pcHold <= 1'b1;
			pc <= others[i];
			@(posedge clock);
			@(negedge clock);
			checkFetch(pcVal, pcStep, pcOk, windowAt(48'h1004), 3'd1, pcOkOk, "held pc");
		end
		@(posedge clock);
		pcHold <= 1'b0;
	endtask

	task automatic flushTest();
		int start;
		fetchPc(48'h1004, 1'b0, 3'd1, 1'b0);
		start = reqLog.size();
		@(posedge clock);
		fetchOp <= fetchOpFlush;
		@(posedge clock);
		fetchOp <= fetchOpNone;
		repeat (2) @(posedge clock);		// New epoch is live from here
		@(negedge clock);
		checkOk(pcOk, pcOkHold, "fetch after flush");
		finishMiss(48'h1004, start);
	endtask

	task automatic forwardTest();
		ringFlitT foreign;
		foreign = '0;
		foreign.seq.node = 8'h11;
		foreign.seq.oddBank = 1'b1;
		foreign.seq.rov = 4'h9;
		foreign.op = ringOther;
		foreign.addr = PcWidth'({$random(seed), $random(seed)});
		foreign.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
		@(posedge clock);
		ringIn <= foreign;
		@(posedge clock);
		ringIn <= '0;
		@(negedge clock);
		checkFlit(ringOut, foreign, "forwarded foreign flit");
	endtask

	initial
	begin
		reset = 1'b1;
		pc = '0;
		pcHold = 1'b0;
		bundleMode = 1'b0;
		fetchOp = fetchOpNone;
		ringIn = '0;
		fork
			watchRing();
			memoryModel();
		join_none
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		coldMissTest();
		hitsTest();
		stepTest();
		holdTest();
		flushTest();
		forwardTest();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/icachePkg.sv
hdl/icacheBank.sv
hdl/icacheFlushControl.sv
hdl/icacheFetchPipe.sv
hdl/icacheRingPort.sv
hdl/icacheTop.sv
test/icacheTb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - hdl/icachePkg.sv
  - hdl/icacheBank.sv
  - hdl/icacheFlushControl.sv
  - hdl/icacheFetchPipe.sv
  - hdl/icacheRingPort.sv
  - hdl/icacheTop.sv
  - target: test
    files:
      - test/icacheTb.sv
